// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    ////////////////////////////////////////
    // Sizes
    localparam int WORD_SIZE  = 16;
    localparam int REG_SIZE   = 2;
    localparam int IMM_SIZE   = 8;
    localparam int JUMP_SIZE  = 12;
    localparam int FUNCT_SIZE = 6;

    // R-type function codes
    localparam logic [FUNCT_SIZE-1:0] FUNCT_ADD = 6'd0;
    localparam logic [FUNCT_SIZE-1:0] FUNCT_SUB = 6'd1;
    localparam logic [FUNCT_SIZE-1:0] FUNCT_AND = 6'd2;
    localparam logic [FUNCT_SIZE-1:0] FUNCT_ORR = 6'd3;
    localparam logic [FUNCT_SIZE-1:0] FUNCT_WWD = 6'd28;
    localparam logic [FUNCT_SIZE-1:0] FUNCT_HLT = 6'd29;

    ////////////////////////////////////////
    // Encodings
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_LHI = 3'd4
    } alu_op_t;

    ////////////////////////////////////////
    // Control and stage boundaries
    typedef struct packed {
        logic    alu_src;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    reg_write;
        logic    reg_dest;   // 1 selects rd, 0 selects rt
        logic    uses_rs;
        logic    uses_rt;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        logic    wwd;
        logic    halt;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [WORD_SIZE-1:0] instr;
        logic [WORD_SIZE-1:0] pc_next;
        logic                 valid;
    } if_id_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [WORD_SIZE-1:0] rs_val;
        logic [WORD_SIZE-1:0] rt_val;
        logic [WORD_SIZE-1:0] imm;
        logic [REG_SIZE-1:0]  dest;
        logic                 valid;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [WORD_SIZE-1:0] alu_result;
        logic [WORD_SIZE-1:0] store_data;
        logic [REG_SIZE-1:0]  dest;
        logic [WORD_SIZE-1:0] rs_val;
        logic                 valid;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [WORD_SIZE-1:0] alu_result;
        logic [WORD_SIZE-1:0] load_data;
        logic [REG_SIZE-1:0]  dest;
        logic [WORD_SIZE-1:0] rs_val;
        logic                 valid;
    } mem_wb_t;

endpackage

// ==== source/reg_read_if.sv ====
`timescale 1ns/1ns

interface reg_read_if;

    logic [cpu_pkg::REG_SIZE-1:0]  rs_addr;
    logic [cpu_pkg::REG_SIZE-1:0]  rt_addr;
    logic [cpu_pkg::WORD_SIZE-1:0] rs_data;
    logic [cpu_pkg::WORD_SIZE-1:0] rt_data;

    // Decode stage side
    modport stage (output rs_addr, rt_addr, input rs_data, rt_data);

    // Register file side
    modport file (input rs_addr, rt_addr, output rs_data, rt_data);

    // Hazard and branch logic only looks
    modport observe (input rs_addr, rt_addr, rs_data, rt_data);

endinterface

// ==== source/pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     enable,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Cleared payload is a bubble with valid low
    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic                          clk,
    input  logic                          reset_n,
    reg_read_if.file                      rd_port,
    input  logic                          write_enable,
    input  logic [cpu_pkg::REG_SIZE-1:0]  write_addr,
    input  logic [cpu_pkg::WORD_SIZE-1:0] write_data
);

    logic [cpu_pkg::WORD_SIZE-1:0] regs [2**cpu_pkg::REG_SIZE];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 2**cpu_pkg::REG_SIZE; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable) begin
            regs[write_addr] <= write_data;
        end
    end

    // Write-through so write-back never has to stall decode
    always_comb begin
        rd_port.rs_data = regs[rd_port.rs_addr];
        rd_port.rt_data = regs[rd_port.rt_addr];
        if (write_enable && write_addr == rd_port.rs_addr) begin
            rd_port.rs_data = write_data;
        end
        if (write_enable && write_addr == rd_port.rt_addr) begin
            rd_port.rt_data = write_data;
        end
    end

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/1ns

module control_unit (
    input  cpu_pkg::opcode_t              opcode,
    input  logic [cpu_pkg::FUNCT_SIZE-1:0] funct,
    output cpu_pkg::ctrl_t                ctrl
);

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = cpu_pkg::ALU_ADD;
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                case (funct)
                    cpu_pkg::FUNCT_ADD,
                    cpu_pkg::FUNCT_SUB,
                    cpu_pkg::FUNCT_AND,
                    cpu_pkg::FUNCT_ORR: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.reg_dest  = 1'b1;
                        ctrl.uses_rs   = 1'b1;
                        ctrl.uses_rt   = 1'b1;
                        case (funct)
                            cpu_pkg::FUNCT_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
                            cpu_pkg::FUNCT_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
                            cpu_pkg::FUNCT_ORR: ctrl.alu_op = cpu_pkg::ALU_OR;
                            default:            ctrl.alu_op = cpu_pkg::ALU_ADD;
                        endcase
                    end
                    cpu_pkg::FUNCT_WWD: begin
                        ctrl.wwd     = 1'b1;
                        ctrl.uses_rs = 1'b1;
                    end
                    cpu_pkg::FUNCT_HLT: ctrl.halt = 1'b1;
                    default: ;
                endcase
            end
            cpu_pkg::OP_ADI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.uses_rs   = 1'b1;
            end
            // Upper byte load ignores rs
            cpu_pkg::OP_LHI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = cpu_pkg::ALU_LHI;
            end
            cpu_pkg::OP_LWD: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.uses_rs    = 1'b1;
            end
            cpu_pkg::OP_SWD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
            end
            cpu_pkg::OP_BNE,
            cpu_pkg::OP_BEQ: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (opcode == cpu_pkg::OP_BNE);
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
            end
            cpu_pkg::OP_JMP: ctrl.jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  logic [cpu_pkg::WORD_SIZE-1:0] a,
    input  logic [cpu_pkg::WORD_SIZE-1:0] b,
    input  cpu_pkg::alu_op_t              op,
    output logic [cpu_pkg::WORD_SIZE-1:0] result
);

    localparam int LOW_BITS = cpu_pkg::WORD_SIZE - cpu_pkg::IMM_SIZE;

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            // Immediate into the upper byte, low byte zero
            cpu_pkg::ALU_LHI: result = {b[cpu_pkg::IMM_SIZE-1:0], {LOW_BITS{1'b0}}};
            default:          result = '0;
        endcase
    end

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
    reg_read_if.observe                   rd_port,
    input  cpu_pkg::ctrl_t                id_ctrl,
    input  logic                          id_valid,
    input  logic [cpu_pkg::WORD_SIZE-1:0] id_pc_next,
    input  logic [cpu_pkg::WORD_SIZE-1:0] id_imm,
    input  logic [cpu_pkg::JUMP_SIZE-1:0] id_jump_field,
    input  logic [cpu_pkg::REG_SIZE-1:0]  ex_dest,
    input  logic [cpu_pkg::REG_SIZE-1:0]  mem_dest,
    input  logic                          ex_write,
    input  logic                          mem_write,
    output logic                          stall,
    output logic                          redirect,
    output logic [cpu_pkg::WORD_SIZE-1:0] target
);

    localparam int PAGE_BITS = cpu_pkg::WORD_SIZE - cpu_pkg::JUMP_SIZE;

    logic rs_hit;
    logic rt_hit;
    logic taken;

    ////////////////////////////////////////
    // Interlock on older writers

    assign rs_hit = id_ctrl.uses_rs &&
                    ((ex_write && ex_dest == rd_port.rs_addr) ||
                     (mem_write && mem_dest == rd_port.rs_addr));
    assign rt_hit = id_ctrl.uses_rt &&
                    ((ex_write && ex_dest == rd_port.rt_addr) ||
                     (mem_write && mem_dest == rd_port.rt_addr));

    assign stall = id_valid && (rs_hit || rt_hit);

    ////////////////////////////////////////
    // Branch and jump resolution

    always_comb begin
        taken = 1'b0;
        if (id_ctrl.branch) begin
            taken = id_ctrl.branch_ne ? (rd_port.rs_data != rd_port.rt_data)
                                      : (rd_port.rs_data == rd_port.rt_data);
        end
    end

    assign redirect = id_valid && !stall && (id_ctrl.jump || taken);

    // Jump keeps the page bits of the next pc
    assign target = id_ctrl.jump
                  ? {id_pc_next[cpu_pkg::WORD_SIZE-1 -: PAGE_BITS], id_jump_field}
                  : id_pc_next + id_imm;

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/1ns

module cpu (
    input  logic                          clk,
    input  logic                          reset_n,
    output logic                          read_m1,
    output logic [cpu_pkg::WORD_SIZE-1:0] address1,
    input  logic [cpu_pkg::WORD_SIZE-1:0] data1,
    output logic                          read_m2,
    output logic                          write_m2,
    output logic [cpu_pkg::WORD_SIZE-1:0] address2,
    inout  logic [cpu_pkg::WORD_SIZE-1:0] data2,
    output logic [cpu_pkg::WORD_SIZE-1:0] num_inst,
    output logic [cpu_pkg::WORD_SIZE-1:0] output_port,
    output logic                          is_halted
);

    localparam int W = cpu_pkg::WORD_SIZE;
    localparam int SIGN_BITS = cpu_pkg::WORD_SIZE - cpu_pkg::IMM_SIZE;

    logic [W-1:0] pc;
    logic [W-1:0] pc_plus_one;
    logic         halt_pending;
    logic         halt_stop;
    logic         id_halt;

    cpu_pkg::if_id_t  if_id_d, if_id_q;
    cpu_pkg::id_ex_t  id_ex_d, id_ex_q;
    cpu_pkg::ex_mem_t ex_mem_d, ex_mem_q;
    cpu_pkg::mem_wb_t mem_wb_d, mem_wb_q;

    cpu_pkg::ctrl_t                id_ctrl;
    logic [W-1:0]                  id_imm;
    logic [cpu_pkg::REG_SIZE-1:0]  id_dest;
    logic                          stall;
    logic                          redirect;
    logic [W-1:0]                  target;
    logic [W-1:0]                  alu_b;
    logic [W-1:0]                  alu_result;
    logic                          wb_write;
    logic [W-1:0]                  wb_data;

    reg_read_if rd_port ();

    ////////////////////////////////////////
    // Fetch

    assign pc_plus_one = pc + 1'b1;
    assign address1    = pc;
    assign read_m1     = !is_halted;

    // Once HLT is decoded nothing younger may enter the pipe
    assign id_halt   = if_id_q.valid && id_ctrl.halt;
    assign halt_stop = halt_pending || id_halt;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc           <= '0;
            halt_pending <= 1'b0;
        end else begin
            if (id_halt) begin
                halt_pending <= 1'b1;
            end
            if (!stall && !halt_stop) begin
                pc <= redirect ? target : pc_plus_one;
            end
        end
    end

    always_comb begin
        if_id_d.instr   = data1;
        if_id_d.pc_next = pc_plus_one;
        if_id_d.valid   = !halt_stop;
    end

    pipe_reg #(.payload_t(cpu_pkg::if_id_t)) if_id_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .enable  (!stall),
        .flush   (redirect),
        .d       (if_id_d),
        .q       (if_id_q)
    );

    ////////////////////////////////////////
    // Decode

    assign rd_port.rs_addr = if_id_q.instr[11:10];
    assign rd_port.rt_addr = if_id_q.instr[9:8];

    assign id_imm  = {{SIGN_BITS{if_id_q.instr[cpu_pkg::IMM_SIZE-1]}},
                      if_id_q.instr[cpu_pkg::IMM_SIZE-1:0]};
    assign id_dest = id_ctrl.reg_dest ? if_id_q.instr[7:6] : if_id_q.instr[9:8];

    control_unit control_unit_i (
        .opcode (cpu_pkg::opcode_t'(if_id_q.instr[15:12])),
        .funct  (if_id_q.instr[cpu_pkg::FUNCT_SIZE-1:0]),
        .ctrl   (id_ctrl)
    );

    register_file register_file_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .rd_port      (rd_port),
        .write_enable (wb_write),
        .write_addr   (mem_wb_q.dest),
        .write_data   (wb_data)
    );

    hazard_unit hazard_unit_i (
        .rd_port       (rd_port),
        .id_ctrl       (id_ctrl),
        .id_valid      (if_id_q.valid),
        .id_pc_next    (if_id_q.pc_next),
        .id_imm        (id_imm),
        .id_jump_field (if_id_q.instr[cpu_pkg::JUMP_SIZE-1:0]),
        .ex_dest       (id_ex_q.dest),
        .mem_dest      (ex_mem_q.dest),
        .ex_write      (id_ex_q.valid && id_ex_q.ctrl.reg_write),
        .mem_write     (ex_mem_q.valid && ex_mem_q.ctrl.reg_write),
        .stall         (stall),
        .redirect      (redirect),
        .target        (target)
    );

    always_comb begin
        id_ex_d.ctrl   = id_ctrl;
        id_ex_d.rs_val = rd_port.rs_data;
        id_ex_d.rt_val = rd_port.rt_data;
        id_ex_d.imm    = id_imm;
        id_ex_d.dest   = id_dest;
        id_ex_d.valid  = if_id_q.valid;
    end

    // A stall turns this slot into a bubble
    pipe_reg #(.payload_t(cpu_pkg::id_ex_t)) id_ex_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .enable  (1'b1),
        .flush   (stall),
        .d       (id_ex_d),
        .q       (id_ex_q)
    );

    ////////////////////////////////////////
    // Execute

    assign alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : id_ex_q.rt_val;

    alu alu_i (
        .a      (id_ex_q.rs_val),
        .b      (alu_b),
        .op     (id_ex_q.ctrl.alu_op),
        .result (alu_result)
    );

    always_comb begin
        ex_mem_d.ctrl       = id_ex_q.ctrl;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = id_ex_q.rt_val;
        ex_mem_d.dest       = id_ex_q.dest;
        ex_mem_d.rs_val     = id_ex_q.rs_val;
        ex_mem_d.valid      = id_ex_q.valid;
    end

    pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .enable  (1'b1),
        .flush   (1'b0),
        .d       (ex_mem_d),
        .q       (ex_mem_q)
    );

    ////////////////////////////////////////
    // Memory

    assign address2 = ex_mem_q.alu_result;
    assign read_m2  = ex_mem_q.valid && ex_mem_q.ctrl.mem_read;
    assign write_m2 = ex_mem_q.valid && ex_mem_q.ctrl.mem_write;
    assign data2    = write_m2 ? ex_mem_q.store_data : 'z;

    always_comb begin
        mem_wb_d.ctrl       = ex_mem_q.ctrl;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = data2;
        mem_wb_d.dest       = ex_mem_q.dest;
        mem_wb_d.rs_val     = ex_mem_q.rs_val;
        mem_wb_d.valid      = ex_mem_q.valid;
    end

    pipe_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .enable  (1'b1),
        .flush   (1'b0),
        .d       (mem_wb_d),
        .q       (mem_wb_q)
    );

    ////////////////////////////////////////
    // Write-back and retirement

    assign wb_write = mem_wb_q.valid && mem_wb_q.ctrl.reg_write;
    assign wb_data  = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst    <= '0;
            output_port <= '0;
            is_halted   <= 1'b0;
        end else if (mem_wb_q.valid) begin
            num_inst <= num_inst + 1'b1;
            if (mem_wb_q.ctrl.wwd) begin
                output_port <= mem_wb_q.rs_val;
            end
            if (mem_wb_q.ctrl.halt) begin
                is_halted <= 1'b1;
            end
        end
    end

endmodule

// ==== verification/tb_memory.sv ====
`timescale 1ns/1ns

module tb_memory (
    input  logic                          clk,
    input  logic                          read_m1,
    input  logic [cpu_pkg::WORD_SIZE-1:0] address1,
    output logic [cpu_pkg::WORD_SIZE-1:0] data1,
    input  logic                          read_m2,
    input  logic                          write_m2,
    input  logic [cpu_pkg::WORD_SIZE-1:0] address2,
    inout  wire  [cpu_pkg::WORD_SIZE-1:0] data2
);

    localparam int ADDR_BITS = 8;
    localparam int DEPTH     = 2**ADDR_BITS;

    // Filled by the testbench before reset is released
    logic [cpu_pkg::WORD_SIZE-1:0] imem [DEPTH];
    logic [cpu_pkg::WORD_SIZE-1:0] dmem [DEPTH];

    // Upper address bits alias onto the same words
    assign data1 = read_m1 ? imem[address1[ADDR_BITS-1:0]] : '0;

    // Read data valid in the same cycle as the strobe
    assign data2 = (read_m2 && !write_m2) ? dmem[address2[ADDR_BITS-1:0]] : 'z;

    always @(posedge clk) begin
        if (write_m2) begin
            dmem[address2[ADDR_BITS-1:0]] <= data2;
        end
    end

endmodule

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;

    localparam int W              = cpu_pkg::WORD_SIZE;
    localparam int MEM_DEPTH      = 256;
    localparam int MAX_EXPECTED   = 64;
    localparam int HALT_TIMEOUT   = 2000;
    localparam int REF_STEP_LIMIT = 1000;
    localparam int SETTLE_CYCLES  = 8;
    localparam logic [31:0] SEED  = 32'h119ae772;

    logic         clk;
    logic         reset_n;
    logic         read_m1;
    logic [W-1:0] address1;
    logic [W-1:0] data1;
    logic         read_m2;
    logic         write_m2;
    logic [W-1:0] address2;
    wire  [W-1:0] data2;
    logic [W-1:0] num_inst;
    logic [W-1:0] output_port;
    logic         is_halted;

    logic [W-1:0] prog [$];
    logic [W-1:0] ref_mem [MEM_DEPTH];
    logic         fetch_ok [MEM_DEPTH];
    logic [W-1:0] exp_out [MAX_EXPECTED];
    logic [W-1:0] exp_store_addr [MAX_EXPECTED];
    logic [W-1:0] exp_store_data [MAX_EXPECTED];
    int           exp_count;
    int           store_count;
    int           ref_retired;

    // Monitor state, advanced on the rising edge
    logic [W-1:0] prev_out;
    int           out_idx;
    int           store_idx;
    logic         halted_seen;

    int errors;
    int timeouts;

    cpu dut_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .data2       (data2),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    tb_memory mem_i (
        .clk      (clk),
        .read_m1  (read_m1),
        .address1 (address1),
        .data1    (data1),
        .read_m2  (read_m2),
        .write_m2 (write_m2),
        .address2 (address2),
        .data2    (data2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Instruction encoding

    function automatic logic [W-1:0] r_type(input logic [1:0] rs, input logic [1:0] rt,
                                            input logic [1:0] rd, input logic [5:0] funct);
        return {cpu_pkg::OP_RTYPE, rs, rt, rd, funct};
    endfunction

    function automatic logic [W-1:0] i_type(input logic [3:0] op, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [W-1:0] j_type(input logic [11:0] target);
        return {cpu_pkg::OP_JMP, target};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic build_program();
        int jump_at;
        // Arithmetic on random operands, back to back
        prog.push_back(i_type(cpu_pkg::OP_ADI, 2'd0, 2'd1, rand_byte()));
        prog.push_back(i_type(cpu_pkg::OP_ADI, 2'd0, 2'd2, rand_byte()));
        prog.push_back(r_type(2'd1, 2'd2, 2'd3, cpu_pkg::FUNCT_ADD));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(r_type(2'd1, 2'd2, 2'd3, cpu_pkg::FUNCT_SUB));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(r_type(2'd3, 2'd1, 2'd3, cpu_pkg::FUNCT_AND));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(r_type(2'd1, 2'd2, 2'd3, cpu_pkg::FUNCT_ORR));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(i_type(cpu_pkg::OP_LHI, 2'd0, 2'd3, rand_byte()));
        prog.push_back(i_type(cpu_pkg::OP_ADI, 2'd3, 2'd3, rand_byte()));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        // Store then load the same word, then load-use on random data
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, cpu_pkg::FUNCT_SUB));
        prog.push_back(i_type(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h20));
        prog.push_back(i_type(cpu_pkg::OP_SWD, 2'd1, 2'd3, 8'h03));
        prog.push_back(i_type(cpu_pkg::OP_LWD, 2'd1, 2'd2, 8'h03));
        prog.push_back(r_type(2'd2, 2'd1, 2'd2, cpu_pkg::FUNCT_ADD));
        prog.push_back(r_type(2'd2, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(i_type(cpu_pkg::OP_LWD, 2'd1, 2'd3, 8'h05));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(i_type(cpu_pkg::OP_SWD, 2'd1, 2'd2, 8'hff));
        // Branches and jump; skipped slots print the marker in r0
        prog.push_back(i_type(cpu_pkg::OP_LHI, 2'd0, 2'd0, 8'hee));
        prog.push_back(i_type(cpu_pkg::OP_BEQ, 2'd3, 2'd3, 8'h01));
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(i_type(cpu_pkg::OP_BNE, 2'd3, 2'd3, 8'h01));
        prog.push_back(r_type(2'd1, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(i_type(cpu_pkg::OP_BNE, 2'd1, 2'd3, 8'h01));
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        jump_at = prog.size();
        prog.push_back(j_type(12'(jump_at + 2)));
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(r_type(2'd2, 2'd0, 2'd0, cpu_pkg::FUNCT_WWD));
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, cpu_pkg::FUNCT_HLT));
    endtask

    task automatic load_memories();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            if (a < prog.size()) begin
                mem_i.imem[a] = prog[a];
            end else begin
                mem_i.imem[a] = r_type(2'd0, 2'd0, 2'd0, cpu_pkg::FUNCT_HLT);
            end
            mem_i.dmem[a] = W'($urandom);
            ref_mem[a]    = mem_i.dmem[a];
        end
    endtask

    ////////////////////////////////////////
    // Instruction-level reference model

    task automatic run_reference();
        logic [W-1:0] regs [4];
        logic [W-1:0] pc;
        logic [W-1:0] next_pc;
        logic [W-1:0] instr;
        logic [W-1:0] imm;
        logic [W-1:0] addr;
        logic [W-1:0] last_out;
        logic [1:0]   rs;
        logic [1:0]   rt;
        logic [1:0]   rd;
        logic         done;
        int           steps;

        for (int i = 0; i < 4; i++) begin
            regs[i] = '0;
        end
        for (int a = 0; a < MEM_DEPTH; a++) begin
            fetch_ok[a] = 1'b0;
        end
        pc          = '0;
        last_out    = '0;
        done        = 1'b0;
        steps       = 0;
        exp_count   = 0;
        store_count = 0;
        ref_retired = 0;
        while (!done && steps < REF_STEP_LIMIT) begin
            instr   = mem_i.imem[pc[7:0]];
            rs      = instr[11:10];
            rt      = instr[9:8];
            rd      = instr[7:6];
            imm     = {{8{instr[7]}}, instr[7:0]};
            addr    = regs[rs] + imm;
            next_pc = pc + 16'd1;
            // Fetch may also reach the slot behind each instruction
            fetch_ok[pc[7:0]] = 1'b1;
            fetch_ok[next_pc[7:0]] = 1'b1;
            case (instr[15:12])
                cpu_pkg::OP_RTYPE: begin
                    case (instr[5:0])
                        cpu_pkg::FUNCT_ADD: regs[rd] = regs[rs] + regs[rt];
                        cpu_pkg::FUNCT_SUB: regs[rd] = regs[rs] - regs[rt];
                        cpu_pkg::FUNCT_AND: regs[rd] = regs[rs] & regs[rt];
                        cpu_pkg::FUNCT_ORR: regs[rd] = regs[rs] | regs[rt];
                        cpu_pkg::FUNCT_HLT: done = 1'b1;
                        cpu_pkg::FUNCT_WWD: begin
                            // Only changes of output_port are visible
                            if (regs[rs] != last_out) begin
                                exp_out[exp_count] = regs[rs];
                                exp_count++;
                                last_out = regs[rs];
                            end
                        end
                        default: ;
                    endcase
                end
                cpu_pkg::OP_ADI: regs[rt] = addr;
                cpu_pkg::OP_LHI: regs[rt] = {instr[7:0], 8'h00};
                cpu_pkg::OP_LWD: regs[rt] = ref_mem[addr[7:0]];
                cpu_pkg::OP_SWD: begin
                    ref_mem[addr[7:0]]          = regs[rt];
                    exp_store_addr[store_count] = addr;
                    exp_store_data[store_count] = regs[rt];
                    store_count++;
                end
                cpu_pkg::OP_BNE: if (regs[rs] != regs[rt]) next_pc = next_pc + imm;
                cpu_pkg::OP_BEQ: if (regs[rs] == regs[rt]) next_pc = next_pc + imm;
                cpu_pkg::OP_JMP: next_pc = {next_pc[15:12], instr[11:0]};
                default: ;
            endcase
            ref_retired++;
            pc = next_pc;
            steps++;
        end
        if (!done) begin
            $display("Reference model did not reach HLT within %0d steps", REF_STEP_LIMIT);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Monitors and assertions

    always @(posedge clk) begin
        if (reset_n) begin
            prev_out    <= '0;
            out_idx     <= 0;
            store_idx   <= 0;
            halted_seen <= 1'b0;
        end else begin
            prev_out <= output_port;
            if (output_port != prev_out) begin
                out_idx <= out_idx + 1;
            end
            if (write_m2) begin
                store_idx <= store_idx + 1;
            end
            halted_seen <= halted_seen || is_halted;
        end
    end

    // Checked mid-cycle where every output is stable
    reset_quiet: assert property (@(negedge clk) reset_n |->
        (!read_m2 && !write_m2 && !is_halted && num_inst == '0 && output_port == '0))
        else report_failure("memory strobes, halt or counters not cleared in reset");

    fetch_active: assert property (@(negedge clk) (!reset_n && !is_halted) |-> read_m1)
        else report_failure("read_m1 low while the processor runs");

    fetch_path: assert property (@(negedge clk) (!reset_n && read_m1) |->
        (address1 < MEM_DEPTH && fetch_ok[address1[7:0]]))
        else report_failure($sformatf("fetch from %h off the executed path", address1));

    port_exclusive: assert property (@(negedge clk) !(read_m2 && write_m2))
        else report_failure("read_m2 and write_m2 high together");

    output_order: assert property (@(negedge clk) (!reset_n && output_port != prev_out) |->
        (out_idx < exp_count && output_port == exp_out[out_idx]))
        else report_failure($sformatf("output_port %h, expected %h (entry %0d)",
                                      output_port, exp_out[out_idx], out_idx));

    store_match: assert property (@(negedge clk) write_m2 |->
        (store_idx < store_count && address2 == exp_store_addr[store_idx] &&
         data2 == exp_store_data[store_idx]))
        else report_failure($sformatf("store %h to %h, expected %h to %h", data2, address2,
                                      exp_store_data[store_idx], exp_store_addr[store_idx]));

    halt_hold: assert property (@(negedge clk) halted_seen |-> (is_halted && !read_m1))
        else report_failure("is_halted dropped or fetch resumed after HLT");

    halt_count: assert property (@(negedge clk) is_halted |-> num_inst == W'(ref_retired))
        else report_failure($sformatf("num_inst %0d at halt, expected %0d",
                                      num_inst, ref_retired));

    task automatic check_final_state();
        assert (out_idx == exp_count)
            else report_failure($sformatf("%0d output_port values, expected %0d",
                                          out_idx, exp_count));
        assert (store_idx == store_count)
            else report_failure($sformatf("%0d stores, expected %0d", store_idx, store_count));
        for (int a = 0; a < MEM_DEPTH; a++) begin
            assert (mem_i.dmem[a] == ref_mem[a])
                else report_failure($sformatf("data memory[%0d] %h, expected %h",
                                              a, mem_i.dmem[a], ref_mem[a]));
        end
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        int seed_result;
        int cycles;

        errors      = 0;
        timeouts    = 0;
        reset_n     = 1'b1;
        seed_result = $urandom(SEED);
        build_program();
        load_memories();
        run_reference();

        // Reset level is high on reset_n
        repeat (2) @(posedge clk);
        #1 reset_n = 1'b0;

        cycles = 0;
        while (!is_halted && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!is_halted) begin
            $display("Timeout: the processor did not halt within %0d cycles", HALT_TIMEOUT);
            timeouts++;
        end else begin
            // Keep the halted-state assertions running for a while
            repeat (SETTLE_CYCLES) @(posedge clk);
            check_final_state();
        end

        $display("Check failures: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/cpu_pkg.sv
source/reg_read_if.sv
source/pipe_reg.sv
source/register_file.sv
source/control_unit.sv
source/alu.sv
source/hazard_unit.sv
source/cpu.sv
verification/tb_memory.sv
verification/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipelined processor

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "STATUS: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
